// ==== source/sram_pkg.sv ====
package sram_pkg;

	// external SRAM geometry
	localparam int ADDR_BITS = 18;
	localparam int DATA_BITS = 16;

	// bus port tag, nonzero means a request
	localparam int TAG_BITS = 4;

	// one scanline of video words
	localparam int LINE_WORDS = 40;
	localparam int LINE_IDX_BITS = 6;

	typedef logic [ADDR_BITS-1:0] sram_addr_t;
	typedef logic [DATA_BITS-1:0] sram_data_t;
	typedef logic [TAG_BITS-1:0] req_tag_t;
	typedef logic [LINE_IDX_BITS-1:0] line_idx_t;

	// one access slot, as chosen by the arbiter
	typedef struct packed {
		logic valid;
		logic owner_vga;
		logic we;
		// byte enables, active high
		logic ub;
		logic lb;
		sram_addr_t addr;
		sram_data_t wdata;
		req_tag_t tag;
		line_idx_t idx;
	} sram_req_t;

	// captured result of one access, leaving the phy
	typedef struct packed {
		logic valid;
		logic owner_vga;
		logic we;
		req_tag_t tag;
		line_idx_t idx;
		sram_data_t rdata;
	} sram_rsp_t;

	// scanline fetcher states
	typedef enum logic {
		IDLE,
		FETCH
	} fetch_state_t;

endpackage

// ==== source/vga_line_fetch.sv ====
`timescale 1ns/1ps

module vga_line_fetch
	import sram_pkg::*;
(
	input  logic       I_clk,
	input  logic       arst_n,
	input  logic       line_start,
	input  sram_addr_t line_base,
	output logic       vga_req,
	output sram_addr_t vga_addr,
	output line_idx_t  vga_idx
);

	fetch_state_t state;
	line_idx_t    count;
	sram_addr_t   base;

	// word counter and state
	always_ff @(posedge I_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				IDLE: begin
					count <= '0;
					if (line_start) begin
						state <= FETCH;
					end
				end
				FETCH: begin
					// a new line_start here is ignored
					if (count == line_idx_t'(LINE_WORDS - 1)) begin
						state <= IDLE;
						count <= '0;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: begin
					state <= IDLE;
					count <= '0;
				end
			endcase
		end
	end

	// base address is latched once per line
	always_ff @(posedge I_clk) begin
		if (state == IDLE && line_start) begin
			base <= line_base;
		end
	end

	// registered request toward the arbiter, one cycle behind the FSM
	always_ff @(posedge I_clk or negedge arst_n) begin
		if (!arst_n) begin
			vga_req <= 1'b0;
		end else begin
			vga_req <= (state == FETCH);
		end
	end

	always_ff @(posedge I_clk) begin
		vga_addr <= base + sram_addr_t'(count);
		vga_idx  <= count;
	end

endmodule

// ==== source/sram_arbiter.sv ====
`timescale 1ns/1ps

module sram_arbiter
	import sram_pkg::*;
(
	input  logic       I_clk,
	input  logic       arst_n,
	input  logic       vga_req,
	input  sram_addr_t vga_addr,
	input  line_idx_t  vga_idx,
	input  req_tag_t   request,
	input  logic       we,
	input  logic       ub,
	input  logic       lb,
	input  sram_addr_t addr,
	input  sram_data_t wdata,
	output logic       stall,
	output sram_req_t  req
);

	sram_req_t nxt;
	logic      bus_take;

	// video always wins, so the bus stalls exactly while it asks
	assign stall    = vga_req;
	assign bus_take = (request != '0) && !vga_req;

	always_comb begin
		nxt = '0;
		if (vga_req) begin
			// video read uses the whole word
			nxt.valid     = 1'b1;
			nxt.owner_vga = 1'b1;
			nxt.we        = 1'b0;
			nxt.ub        = 1'b1;
			nxt.lb        = 1'b1;
			nxt.addr      = vga_addr;
			nxt.idx       = vga_idx;
		end else if (bus_take) begin
			nxt.valid     = 1'b1;
			nxt.owner_vga = 1'b0;
			nxt.we        = we;
			nxt.ub        = ub;
			nxt.lb        = lb;
			nxt.addr      = addr;
			nxt.wdata     = wdata;
			nxt.tag       = request;
		end
	end

	// one slot per cycle toward the phy
	always_ff @(posedge I_clk or negedge arst_n) begin
		if (!arst_n) begin
			req <= '0;
		end else begin
			req <= nxt;
		end
	end

endmodule

// ==== source/sram_phy.sv ====
`timescale 1ns/1ps

module sram_phy
	import sram_pkg::*;
(
	input  logic       I_clk,
	input  logic       arst_n,
	input  sram_req_t  req,
	output sram_addr_t sram_addr,
	output sram_data_t sram_data_out,
	output logic       sram_data_oe,
	input  sram_data_t sram_data_in,
	output logic       sram_ce_n,
	output logic       sram_oe_n,
	output logic       sram_we_n,
	output logic       sram_ub_n,
	output logic       sram_lb_n,
	output sram_rsp_t  rsp
);

	// descriptor of the access currently on the pins
	logic      pin_valid;
	logic      pin_owner_vga;
	logic      pin_we;
	req_tag_t  pin_tag;
	line_idx_t pin_idx;

	// chip stays selected
	assign sram_ce_n = 1'b0;

	// active-low controls, idle levels when no request
	always_ff @(posedge I_clk or negedge arst_n) begin
		if (!arst_n) begin
			sram_oe_n    <= 1'b1;
			sram_we_n    <= 1'b1;
			sram_ub_n    <= 1'b1;
			sram_lb_n    <= 1'b1;
			sram_data_oe <= 1'b0;
		end else if (req.valid) begin
			sram_oe_n    <= req.we;
			sram_we_n    <= !req.we;
			sram_ub_n    <= !req.ub;
			sram_lb_n    <= !req.lb;
			sram_data_oe <= req.we;
		end else begin
			sram_oe_n    <= 1'b1;
			sram_we_n    <= 1'b1;
			sram_ub_n    <= 1'b1;
			sram_lb_n    <= 1'b1;
			sram_data_oe <= 1'b0;
		end
	end

	// address and write data registered with the controls
	always_ff @(posedge I_clk) begin
		sram_addr     <= req.addr;
		sram_data_out <= req.wdata;
		pin_tag       <= req.tag;
		pin_idx       <= req.idx;
	end

	always_ff @(posedge I_clk or negedge arst_n) begin
		if (!arst_n) begin
			pin_valid     <= 1'b0;
			pin_owner_vga <= 1'b0;
			pin_we        <= 1'b0;
		end else begin
			pin_valid     <= req.valid;
			pin_owner_vga <= req.owner_vga;
			pin_we        <= req.we;
		end
	end

	// read data settles during the pin cycle, sampled at its end
	always_ff @(posedge I_clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp <= '0;
		end else begin
			rsp.valid     <= pin_valid;
			rsp.owner_vga <= pin_owner_vga;
			rsp.we        <= pin_we;
			rsp.tag       <= pin_tag;
			rsp.idx       <= pin_idx;
			rsp.rdata     <= sram_data_in;
		end
	end

endmodule

// ==== source/sram_response.sv ====
`timescale 1ns/1ps

module sram_response
	import sram_pkg::*;
(
	input  logic       I_clk,
	input  logic       arst_n,
	input  sram_rsp_t  rsp,
	output req_tag_t   ack,
	output sram_data_t rdata,
	output logic       wr_en,
	output line_idx_t  wr_idx,
	output sram_data_t wr_data
);

	logic bus_rsp;
	logic vga_rsp;

	assign bus_rsp = rsp.valid && !rsp.owner_vga;
	assign vga_rsp = rsp.valid && rsp.owner_vga;

	// strobes, one cycle each
	always_ff @(posedge I_clk or negedge arst_n) begin
		if (!arst_n) begin
			ack   <= '0;
			wr_en <= 1'b0;
		end else begin
			ack   <= bus_rsp ? rsp.tag : '0;
			wr_en <= vga_rsp;
		end
	end

	// bus data, zero for writes
	always_ff @(posedge I_clk) begin
		if (bus_rsp) begin
			rdata <= rsp.we ? '0 : rsp.rdata;
		end
	end

	// pixel side expects the bytes in the other order
	always_ff @(posedge I_clk) begin
		if (vga_rsp) begin
			wr_idx  <= rsp.idx;
			wr_data <= {rsp.rdata[7:0], rsp.rdata[15:8]};
		end
	end

endmodule

// ==== source/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer
	import sram_pkg::*;
(
	input  logic       I_clk,
	input  logic       wr_en,
	input  line_idx_t  wr_idx,
	input  sram_data_t wr_data,
	input  line_idx_t  rd_idx,
	output sram_data_t rd_data
);

	sram_data_t mem [LINE_WORDS];

	// write port from the response stage
	always_ff @(posedge I_clk) begin
		if (wr_en && (wr_idx < line_idx_t'(LINE_WORDS))) begin
			mem[wr_idx] <= wr_data;
		end
	end

	// registered pixel read, indices past the line read as zero
	always_ff @(posedge I_clk) begin
		if (rd_idx < line_idx_t'(LINE_WORDS)) begin
			rd_data <= mem[rd_idx];
		end else begin
			rd_data <= '0;
		end
	end

endmodule

// ==== source/sram_vga_subsystem.sv ====
`timescale 1ns/1ps

module sram_vga_subsystem
	import sram_pkg::*;
(
	input  logic       I_clk,
	input  logic       arst_n,
	// memory bus port
	input  req_tag_t   request,
	input  logic       we,
	input  logic       ub,
	input  logic       lb,
	input  sram_addr_t addr,
	input  sram_data_t wdata,
	output sram_data_t rdata,
	output req_tag_t   ack,
	output logic       stall,
	// video side
	input  logic       line_start,
	input  sram_addr_t line_base,
	input  line_idx_t  pix_idx,
	output sram_data_t pix_data,
	// SRAM pins, data bus split
	output sram_addr_t sram_addr,
	output sram_data_t sram_data_out,
	output logic       sram_data_oe,
	input  sram_data_t sram_data_in,
	output logic       sram_ce_n,
	output logic       sram_oe_n,
	output logic       sram_we_n,
	output logic       sram_ub_n,
	output logic       sram_lb_n
);

	logic       vga_req;
	sram_addr_t vga_addr;
	line_idx_t  vga_idx;
	sram_req_t  arb_req;
	sram_rsp_t  phy_rsp;
	logic       wr_en;
	line_idx_t  wr_idx;
	sram_data_t wr_data;

	vga_line_fetch u_fetch (
		.I_clk      (I_clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.line_base  (line_base),
		.vga_req    (vga_req),
		.vga_addr   (vga_addr),
		.vga_idx    (vga_idx)
	);

	sram_arbiter u_arbiter (
		.I_clk    (I_clk),
		.arst_n   (arst_n),
		.vga_req  (vga_req),
		.vga_addr (vga_addr),
		.vga_idx  (vga_idx),
		.request  (request),
		.we       (we),
		.ub       (ub),
		.lb       (lb),
		.addr     (addr),
		.wdata    (wdata),
		.stall    (stall),
		.req      (arb_req)
	);

	sram_phy u_phy (
		.I_clk         (I_clk),
		.arst_n        (arst_n),
		.req           (arb_req),
		.sram_addr     (sram_addr),
		.sram_data_out (sram_data_out),
		.sram_data_oe  (sram_data_oe),
		.sram_data_in  (sram_data_in),
		.sram_ce_n     (sram_ce_n),
		.sram_oe_n     (sram_oe_n),
		.sram_we_n     (sram_we_n),
		.sram_ub_n     (sram_ub_n),
		.sram_lb_n     (sram_lb_n),
		.rsp           (phy_rsp)
	);

	sram_response u_response (
		.I_clk   (I_clk),
		.arst_n  (arst_n),
		.rsp     (phy_rsp),
		.ack     (ack),
		.rdata   (rdata),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data)
	);

	line_buffer u_line_buffer (
		.I_clk   (I_clk),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.rd_idx  (pix_idx),
		.rd_data (pix_data)
	);

endmodule

// ==== dv/sram_model.sv ====
`timescale 1ns/1ps

module sram_model
	import sram_pkg::*;
(
	input  sram_addr_t sram_addr,
	input  sram_data_t sram_data_out,
	input  logic       sram_data_oe,
	output sram_data_t sram_data_in,
	input  logic       sram_ce_n,
	input  logic       sram_oe_n,
	input  logic       sram_we_n,
	input  logic       sram_ub_n,
	input  logic       sram_lb_n
);

	sram_data_t mem [1 << ADDR_BITS];
	sram_data_t bus;

	// controller drives the bus while writing, the array while oe_n is low
	assign bus = sram_data_oe ? sram_data_out :
		((!sram_ce_n && !sram_oe_n) ? mem[sram_addr] : '0);
	assign sram_data_in = bus;

	// write pulse, taken once the pins have settled after the clock edge
	always @(sram_we_n or sram_ub_n or sram_lb_n or sram_addr or bus) begin
		#1;
		if (!sram_ce_n && !sram_we_n) begin
			if (!sram_ub_n) begin
				mem[sram_addr][15:8] = bus[15:8];
			end
			if (!sram_lb_n) begin
				mem[sram_addr][7:0] = bus[7:0];
			end
		end
	end

endmodule

// ==== dv/tb_sram_vga.sv ====
`timescale 1ns/1ps

module tb_sram_vga
	import sram_pkg::*;
();

	localparam int TIMEOUT = 200;
	localparam int N_WORDS = 12;
	// last line word reaches the buffer 4 clocks after stall falls
	localparam int FILL_LAG = 4;

	typedef struct packed {
		req_tag_t    tag;
		logic        we;
		sram_data_t  data;
		logic [31:0] due;
	} exp_t;

	logic I_clk, arst_n, we, ub, lb, stall, line_start;
	req_tag_t request, ack;
	sram_addr_t addr, line_base, sram_addr;
	sram_data_t wdata, rdata, pix_data, sram_data_out, sram_data_in;
	line_idx_t pix_idx;
	logic sram_data_oe, sram_ce_n, sram_oe_n, sram_we_n, sram_ub_n, sram_lb_n;

	exp_t pend [$];
	sram_data_t shadow [sram_addr_t];
	logic [31:0] lcg_state = 32'ha8ed;
	logic [31:0] cycle = '0;
	int stalled_cycles;
	string test_name;

	sram_vga_subsystem DUT (.*);
	sram_model u_sram (.*);

	initial I_clk = 1'b0;
	always #5 I_clk = ~I_clk;
	always @(posedge I_clk) cycle <= cycle + 1;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic req_tag_t new_tag();
		req_tag_t t;
		t = req_tag_t'(next_random() >> 28);
		return (t == '0) ? req_tag_t'(1) : t;
	endfunction

	// reference for a byte-enabled write
	function automatic sram_data_t merge_lanes(sram_data_t old, sram_data_t d, logic u, logic l);
		return {u ? d[15:8] : old[15:8], l ? d[7:0] : old[7:0]};
	endfunction

	function automatic sram_data_t swap_bytes(sram_data_t d);
		return {d[7:0], d[15:8]};
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	// hold the request until stall is low, then record what must come back
	task automatic issue(input req_tag_t tag, input logic wr, input logic u, input logic l,
			input sram_addr_t a, input sram_data_t d);
		exp_t e;
		int waited;
		waited = 0;
		request = tag;
		we = wr;
		ub = u;
		lb = l;
		addr = a;
		wdata = d;
		while (stall) begin
			@(negedge I_clk);
			waited++;
			if (waited > TIMEOUT) begin
				$display("bus request in %s was never accepted", test_name);
				abort_run();
			end
		end
		stalled_cycles = waited;
		if (wr) begin
			shadow[a] = merge_lanes(shadow.exists(a) ? shadow[a] : '0, d, u, l);
		end
		e.tag = tag;
		e.we = wr;
		e.data = wr ? '0 : shadow[a];
		e.due = cycle + 4;
		pend.push_back(e);
		@(negedge I_clk);
	endtask

	task automatic drain();
		int n;
		request = '0;
		n = 0;
		while (pend.size() != 0) begin
			@(negedge I_clk);
			n++;
			if (n > TIMEOUT) begin
				$display("%0d acks still outstanding in %s", pend.size(), test_name);
				abort_run();
			end
		end
	endtask

	task automatic run_fetch(input sram_addr_t base);
		int n;
		line_base = base;
		line_start = 1'b1;
		@(negedge I_clk);
		line_start = 1'b0;
		n = 0;
		while (!stall) begin
			@(negedge I_clk);
			n++;
			if (n > TIMEOUT) begin
				$display("stall never rose after line_start in %s", test_name);
				abort_run();
			end
		end
	endtask

	task automatic count_stall();
		int n;
		n = 0;
		while (stall) begin
			@(negedge I_clk);
			n++;
			if (n > TIMEOUT) begin
				$display("stall stuck high in %s", test_name);
				abort_run();
			end
		end
		assert (n == LINE_WORDS) else begin
			$display("MISMATCH %s stall cycles expected %0d actual %0d", test_name, LINE_WORDS, n);
			abort_run();
		end
	endtask

	task automatic check_line(input sram_addr_t base);
		sram_data_t want;
		for (int i = 0; i < LINE_WORDS; i++) begin
			pix_idx = line_idx_t'(i);
			@(negedge I_clk);
			want = swap_bytes(shadow[base + sram_addr_t'(i)]);
			assert (pix_data == want) else begin
				$display("MISMATCH %s word %0d expected %04h actual %04h",
					test_name, i, want, pix_data);
				abort_run();
			end
		end
	endtask

	// every ack must land exactly when the oldest access is due
	always @(negedge I_clk) begin : compare_acks
		exp_t head;
		if (arst_n) begin
			if (pend.size() != 0 && pend[0].due == cycle) begin
				head = pend.pop_front();
				assert (ack == head.tag) else begin
					$display("MISMATCH %s ack expected %0h actual %0h", test_name, head.tag, ack);
					abort_run();
				end
				assert (head.we || rdata == head.data) else begin
					$display("MISMATCH %s rdata expected %04h actual %04h",
						test_name, head.data, rdata);
					abort_run();
				end
			end else begin
				assert (ack == '0) else begin
					$display("ack %0h arrived in %s with no access due", ack, test_name);
					abort_run();
				end
			end
		end
	end

	initial begin
		sram_addr_t addrs [N_WORDS];
		sram_addr_t base;
		request = '0;
		{we, ub, lb, line_start} = '0;
		addr = '0;
		wdata = '0;
		line_base = '0;
		pix_idx = '0;
		arst_n = 1'b0;
		repeat (16) @(negedge I_clk);
		arst_n = 1'b1;
		@(negedge I_clk);

		test_name = "reset_idle";
		assert ({ack, stall, sram_ce_n, sram_we_n, sram_oe_n, sram_ub_n, sram_lb_n,
				sram_data_oe} == {4'h0, 7'b0011110}) else begin
			$display("MISMATCH %s expected %03h actual %03h", test_name, {4'h0, 7'b0011110},
				{ack, stall, sram_ce_n, sram_we_n, sram_oe_n, sram_ub_n, sram_lb_n,
				sram_data_oe});
			abort_run();
		end

		test_name = "word_write_read";
		for (int i = 0; i < N_WORDS; i++) begin
			addrs[i] = sram_addr_t'(next_random() >> 14);
			issue(new_tag(), 1'b1, 1'b1, 1'b1, addrs[i], sram_data_t'(next_random() >> 16));
		end
		for (int i = 0; i < N_WORDS; i++) begin
			issue(new_tag(), 1'b0, 1'b1, 1'b1, addrs[i], '0);
		end
		drain();

		test_name = "byte_lanes";
		for (int i = 0; i < N_WORDS; i++) begin
			issue(new_tag(), 1'b1, i[0], !i[0], addrs[i], sram_data_t'(next_random() >> 16));
		end
		for (int i = 0; i < N_WORDS; i++) begin
			issue(new_tag(), 1'b0, 1'b1, 1'b1, addrs[i], '0);
		end
		drain();

		test_name = "line_fetch";
		base = sram_addr_t'(next_random() >> 14);
		for (int i = 0; i < LINE_WORDS; i++) begin
			issue(new_tag(), 1'b1, 1'b1, 1'b1, base + sram_addr_t'(i),
				sram_data_t'(next_random() >> 16));
		end
		drain();
		run_fetch(base);
		count_stall();
		repeat (FILL_LAG) @(negedge I_clk);
		check_line(base);

		test_name = "held_during_fetch";
		// fresh line contents so the second fetch must really land
		for (int i = 0; i < LINE_WORDS; i++) begin
			issue(new_tag(), 1'b1, 1'b1, 1'b1, base + sram_addr_t'(i),
				sram_data_t'(next_random() >> 16));
		end
		drain();
		run_fetch(base);
		issue(new_tag(), 1'b1, 1'b1, 1'b1, base + 18'd200, sram_data_t'(next_random() >> 16));
		assert (stalled_cycles == LINE_WORDS) else begin
			$display("MISMATCH %s held cycles expected %0d actual %0d",
				test_name, LINE_WORDS, stalled_cycles);
			abort_run();
		end
		issue(new_tag(), 1'b0, 1'b1, 1'b1, base + 18'd200, '0);
		drain();
		repeat (FILL_LAG) @(negedge I_clk);
		check_line(base);

		$display("Test passed");
		$finish;
	end

endmodule

// ==== all.f ====
source/sram_pkg.sv
source/vga_line_fetch.sv
source/sram_arbiter.sv
source/sram_phy.sv
source/sram_response.sv
source/line_buffer.sv
source/sram_vga_subsystem.sv
dv/sram_model.sv
dv/tb_sram_vga.sv

// ==== Makefile ====
TOP             ?= tb_sram_vga
SIM_DIR         ?= sim_build
FILE_LIST       ?= all.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
PASS_TEXT       ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILE_LIST)

# output goes to the terminal and through grep, nothing is stored
run: compile
	./$(SIM_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(SIM_DIR)
